/* logic/exu_macros.svh */
////////////////////////////////////////
// EXU width definitions
// Field widths fixed by the command word
////////////////////////////////////////

`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// Data word carried by registers, ALU and shifter
`define EXU_DATA_W 32

// Register address, 32 architectural registers
`define EXU_REG_AW 5

// Shift amount, low bits of operand B
`define EXU_SHAMT_W 5

// Signed immediate of the register-immediate format
`define EXU_IMM_W 18

`endif

/* logic/exu_pkg.sv */
////////////////////////////////////////
// EXU package
// Function codes and command word formats
////////////////////////////////////////

`default_nettype none

`include "exu_macros.svh"

package exu_pkg;

  // ALU and shifter function codes
  typedef enum logic [2:0] {
    FN_ADD = 3'd0,
    FN_SUB = 3'd1,
    FN_AND = 3'd2,
    FN_OR  = 3'd3,
    FN_XOR = 3'd4,
    FN_SLT = 3'd5,
    FN_SLL = 3'd6,
    FN_SRL = 3'd7
  } alu_fn_e;

  // Register-register format, imm_flag is 0
  typedef struct packed {
    logic                   imm_flag;
    alu_fn_e                fn;
    logic [`EXU_REG_AW-1:0] rd;
    logic [`EXU_REG_AW-1:0] rs1;
    logic [`EXU_REG_AW-1:0] rs2;
    // Reserved, ignored by the decoder
    logic [12:0]            pad;
  } cmd_r_t;

  // Register-immediate format, imm_flag is 1
  typedef struct packed {
    logic                        imm_flag;
    alu_fn_e                     fn;
    logic [`EXU_REG_AW-1:0]      rd;
    logic [`EXU_REG_AW-1:0]      rs1;
    logic signed [`EXU_IMM_W-1:0] imm;
  } cmd_i_t;

  // Flag and function sit at the same bits in both views
  typedef union packed {
    cmd_r_t r;
    cmd_i_t i;
  } cmd_u;

endpackage

`default_nettype wire

/* logic/regfile_ff.sv */
////////////////////////////////////////
// Flip-flop register file
// 2 read ports, 1 write port, x0 is zero
////////////////////////////////////////

`default_nettype none

`include "exu_macros.svh"

module regfile_ff #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Read port A
  input  logic [`EXU_REG_AW-1:0] raddr_a_i,
  output logic [DATA_WIDTH-1:0]  rdata_a_o,
  // Read port B
  input  logic [`EXU_REG_AW-1:0] raddr_b_i,
  output logic [DATA_WIDTH-1:0]  rdata_b_o,
  // Write port A
  input  logic [`EXU_REG_AW-1:0] waddr_a_i,
  input  logic [DATA_WIDTH-1:0]  wdata_a_i,
  input  logic                   we_a_i
);

  localparam int NUM_WORDS = 2**`EXU_REG_AW;

  logic [NUM_WORDS-1:0][DATA_WIDTH-1:0] regs;
  logic [NUM_WORDS-1:0]                 we_dec;

  // One-hot write enables from the write address
  always_comb begin
    we_dec = '0;
    we_dec[waddr_a_i] = we_a_i;
  end

  // x0 never holds state
  assign regs[0] = '0;

  // Registers 1 to 31
  for (genvar r = 1; r < NUM_WORDS; r++) begin : g_reg
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        regs[r] <= '0;
      end else if (we_dec[r]) begin
        regs[r] <= wdata_a_i;
      end
    end
  end

  // Combinational reads
  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

  // x0 reads zero on both ports, whatever was written to it
  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    ((raddr_a_i == '0) |-> (rdata_a_o == '0)) and
    ((raddr_b_i == '0) |-> (rdata_b_o == '0)));

endmodule

`default_nettype wire

/* logic/exu_alu.sv */
////////////////////////////////////////
// EXU single-cycle ALU
////////////////////////////////////////

`default_nettype none

`include "exu_macros.svh"

module exu_alu (
  input  exu_pkg::alu_fn_e        fn_i,
  input  logic [`EXU_DATA_W-1:0]  op_a_i,
  input  logic [`EXU_DATA_W-1:0]  op_b_i,
  output logic [`EXU_DATA_W-1:0]  result_o
);

  logic [`EXU_DATA_W-1:0] sum;
  logic [`EXU_DATA_W-1:0] diff;
  logic                   sign_a;
  logic                   sign_b;
  logic                   lt_signed;

  ////////////////////////////////////////
  // Arithmetic
  ////////////////////////////////////////

  assign sum  = op_a_i + op_b_i;
  assign diff = op_a_i - op_b_i;

  // Signed compare from the subtractor
  // Differing signs decide directly, else the difference sign does
  assign sign_a    = op_a_i[`EXU_DATA_W-1];
  assign sign_b    = op_b_i[`EXU_DATA_W-1];
  assign lt_signed = (sign_a != sign_b) ? sign_a : diff[`EXU_DATA_W-1];

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin
    case (fn_i)
      exu_pkg::FN_ADD: result_o = sum;
      exu_pkg::FN_SUB: result_o = diff;
      exu_pkg::FN_AND: result_o = op_a_i & op_b_i;
      exu_pkg::FN_OR:  result_o = op_a_i | op_b_i;
      exu_pkg::FN_XOR: result_o = op_a_i ^ op_b_i;
      // Zero-extended compare flag
      exu_pkg::FN_SLT: result_o = {{(`EXU_DATA_W-1){1'b0}}, lt_signed};
      // Shifts are handled by the shift timer
      default:         result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/exu_shift_timer.sv */
////////////////////////////////////////
// EXU serial shifter
// Shifts one bit per clock, pulses done
////////////////////////////////////////

`default_nettype none

`include "exu_macros.svh"

module exu_shift_timer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start_i,
  input  logic                    dir_right_i,
  input  logic [`EXU_SHAMT_W-1:0] shamt_i,
  input  logic [`EXU_DATA_W-1:0]  value_i,
  output logic                    done_o,
  output logic [`EXU_DATA_W-1:0]  result_o
);

  logic                    busy_q;
  logic                    dir_q;
  logic [`EXU_SHAMT_W-1:0] cnt_q;
  logic [`EXU_DATA_W-1:0]  val_q;

  // Count reaching zero ends the run
  assign done_o   = busy_q && (cnt_q == '0);
  assign result_o = val_q;

  // Control: busy flag, remaining count, direction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      dir_q  <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      dir_q  <= dir_right_i;
      cnt_q  <= shamt_i;
    end else if (busy_q) begin
      if (cnt_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Data path, logical shift with zero fill
  always_ff @(posedge clk) begin
    if (start_i) begin
      val_q <= value_i;
    end else if (busy_q && (cnt_q != '0)) begin
      val_q <= dir_q ? {1'b0, val_q[`EXU_DATA_W-1:1]} : {val_q[`EXU_DATA_W-2:0], 1'b0};
    end
  end

  a_no_done_on_start: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> !done_o);

endmodule

`default_nettype wire

/* logic/exu_ctrl_fsm.sv */
////////////////////////////////////////
// EXU control sequencer
// Accepts a command, runs it, writes back
////////////////////////////////////////

`default_nettype none

`include "exu_macros.svh"

module exu_ctrl_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  // Command port
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  input  exu_pkg::cmd_u           cmd_i,
  // Response port
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output logic [`EXU_DATA_W-1:0]  rsp_data_o,
  // Register file
  output logic [`EXU_REG_AW-1:0]  raddr_a_o,
  output logic [`EXU_REG_AW-1:0]  raddr_b_o,
  output logic [`EXU_REG_AW-1:0]  waddr_o,
  input  logic [`EXU_DATA_W-1:0]  rdata_a_i,
  input  logic [`EXU_DATA_W-1:0]  rdata_b_i,
  output logic                    we_o,
  // ALU
  output exu_pkg::alu_fn_e        alu_fn_o,
  output logic [`EXU_DATA_W-1:0]  op_b_o,
  input  logic [`EXU_DATA_W-1:0]  alu_result_i,
  // Shift timer
  output logic                    shift_start_o,
  output logic                    shift_right_o,
  input  logic                    shift_done_i,
  input  logic [`EXU_DATA_W-1:0]  shift_result_i
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_EXEC  = 2'd1;
  localparam logic [1:0] ST_SHIFT = 2'd2;
  localparam logic [1:0] ST_RESP  = 2'd3;

  logic [1:0]             state_q;
  logic [1:0]             state_d;
  logic                   wb_q;
  logic                   wb_d;
  exu_pkg::cmd_u          cmd_q;
  logic [`EXU_DATA_W-1:0] res_q;
  logic [`EXU_DATA_W-1:0] imm_ext;
  logic                   is_shift;
  logic                   use_shifter;

  ////////////////////////////////////////
  // Decode of the held command
  ////////////////////////////////////////

  assign raddr_a_o = cmd_q.r.rs1;
  assign raddr_b_o = cmd_q.r.rs2;
  assign waddr_o   = cmd_q.r.rd;
  assign alu_fn_o  = cmd_q.r.fn;

  // Operand B is rs2 or the sign-extended immediate
  assign imm_ext = {{(`EXU_DATA_W-`EXU_IMM_W){cmd_q.i.imm[`EXU_IMM_W-1]}}, cmd_q.i.imm};
  assign op_b_o  = cmd_q.r.imm_flag ? imm_ext : rdata_b_i;

  assign is_shift = (cmd_q.r.fn == exu_pkg::FN_SLL) || (cmd_q.r.fn == exu_pkg::FN_SRL);
  // Zero-amount shift skips the shifter, same two-edge latency as the ALU
  assign use_shifter = is_shift && (op_b_o[`EXU_SHAMT_W-1:0] != '0);

  assign shift_start_o = (state_q == ST_EXEC) && use_shifter;
  assign shift_right_o = (cmd_q.r.fn == exu_pkg::FN_SRL);

  ////////////////////////////////////////
  // Handshakes and write-back
  ////////////////////////////////////////

  assign cmd_ready_o = (state_q == ST_IDLE);
  assign rsp_valid_o = (state_q == ST_RESP);

  // Write on the edge that enters RESP
  assign we_o = ((state_q == ST_EXEC) && wb_q) || ((state_q == ST_SHIFT) && shift_done_i);

  // Doubles as register write data
  assign rsp_data_o = (state_q == ST_SHIFT) ? shift_result_i : res_q;

  always_comb begin
    state_d = state_q;
    wb_d    = wb_q;
    case (state_q)
      ST_IDLE: begin
        if (cmd_valid_i) state_d = ST_EXEC;
      end
      ST_EXEC: begin
        if (use_shifter) begin
          state_d = ST_SHIFT;
        end else if (!wb_q) begin
          // First cycle captures the result
          wb_d = 1'b1;
        end else begin
          wb_d    = 1'b0;
          state_d = ST_RESP;
        end
      end
      ST_SHIFT: begin
        if (shift_done_i) state_d = ST_RESP;
      end
      default: begin
        if (rsp_ready_i) state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      wb_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      wb_q    <= wb_d;
    end
  end

  // Command and result holding registers
  always_ff @(posedge clk) begin
    if (cmd_valid_i && cmd_ready_o) begin
      cmd_q <= cmd_i;
    end
    if ((state_q == ST_EXEC) && !use_shifter && !wb_q) begin
      res_q <= is_shift ? rdata_a_i : alu_result_i;
    end else if ((state_q == ST_SHIFT) && shift_done_i) begin
      res_q <= shift_result_i;
    end
  end

  // Response holds until the host takes it
  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_data_o)));

endmodule

`default_nettype wire

/* logic/exu_top.sv */
////////////////////////////////////////
// EXU top level
// Sequencer, register file, ALU, shifter
////////////////////////////////////////

`default_nettype none

`include "exu_macros.svh"

module exu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  exu_pkg::cmd_u          cmd_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [`EXU_DATA_W-1:0] rsp_data_o
);

  logic [`EXU_REG_AW-1:0] raddr_a;
  logic [`EXU_REG_AW-1:0] raddr_b;
  logic [`EXU_REG_AW-1:0] waddr;
  logic [`EXU_DATA_W-1:0] rdata_a;
  logic [`EXU_DATA_W-1:0] rdata_b;
  logic                   we;
  exu_pkg::alu_fn_e       alu_fn;
  logic [`EXU_DATA_W-1:0] op_b;
  logic [`EXU_DATA_W-1:0] alu_result;
  logic                   shift_start;
  logic                   shift_right;
  logic                   shift_done;
  logic [`EXU_DATA_W-1:0] shift_result;

  // Response data is also the write-back value
  exu_ctrl_fsm u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_o    (cmd_ready_o),
    .cmd_i          (cmd_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_data_o     (rsp_data_o),
    .raddr_a_o      (raddr_a),
    .raddr_b_o      (raddr_b),
    .waddr_o        (waddr),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .we_o           (we),
    .alu_fn_o       (alu_fn),
    .op_b_o         (op_b),
    .alu_result_i   (alu_result),
    .shift_start_o  (shift_start),
    .shift_right_o  (shift_right),
    .shift_done_i   (shift_done),
    .shift_result_i (shift_result)
  );

  regfile_ff #(
    .DATA_WIDTH (`EXU_DATA_W)
  ) u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (raddr_a),
    .rdata_a_o (rdata_a),
    .raddr_b_i (raddr_b),
    .rdata_b_o (rdata_b),
    .waddr_a_i (waddr),
    .wdata_a_i (rsp_data_o),
    .we_a_i    (we)
  );

  exu_alu u_alu (
    .fn_i     (alu_fn),
    .op_a_i   (rdata_a),
    .op_b_i   (op_b),
    .result_o (alu_result)
  );

  // Amount from the low bits of operand B
  exu_shift_timer u_shift (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (shift_start),
    .dir_right_i (shift_right),
    .shamt_i     (op_b[`EXU_SHAMT_W-1:0]),
    .value_i     (rdata_a),
    .done_o      (shift_done),
    .result_o    (shift_result)
  );

endmodule

`default_nettype wire

/* test/tb_clkgen.sv */
////////////////////////////////////////
// Testbench clock and reset generator
////////////////////////////////////////

`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free-running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset low for a fixed count of rising edges, released off the edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* test/tb_exu.sv */
////////////////////////////////////////
// EXU testbench
// Table-driven commands checked against a register mirror
////////////////////////////////////////

`default_nettype none

`include "exu_macros.svh"

module tb_exu;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DRIVE_DLY       = 1;
  localparam int RESET_CYCLES    = 8;
  localparam int CYCLES_PER_TEST = 50;

  logic                   clk;
  logic                   rst_n;
  logic                   cmd_valid_i;
  logic                   cmd_ready_o;
  exu_pkg::cmd_u          cmd_i;
  logic                   rsp_valid_o;
  logic                   rsp_ready_i;
  logic [`EXU_DATA_W-1:0] rsp_data_o;

  integer seed;
  int     err_cnt;
  int     pass_cnt;
  int     rsp_seen;
  int     num_tests;

  // Register mirror plus the table of commands, results and latencies
  logic [`EXU_DATA_W-1:0] mirror [2**`EXU_REG_AW];
  exu_pkg::cmd_u          tbl_cmd [$];
  logic [`EXU_DATA_W-1:0] tbl_exp [$];
  int                     tbl_lat [$];

  tb_clkgen #(
    .PERIOD_NS    (4),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  exu_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_o  (rsp_data_o)
  );

  ////////////////////////////////////////
  // Reference model and table
  ////////////////////////////////////////

  // Runs one command on the mirror and records the expected response
  function automatic void append_entry(input exu_pkg::cmd_u cmd);
    logic [`EXU_DATA_W-1:0] a;
    logic [`EXU_DATA_W-1:0] b;
    logic [`EXU_DATA_W-1:0] res;
    logic                   shift;
    a = mirror[cmd.r.rs1];
    // Immediate is sign-extended to the data width
    if (cmd.r.imm_flag) begin
      b = 32'($signed(cmd.i.imm));
    end else begin
      b = mirror[cmd.r.rs2];
    end
    shift = (cmd.r.fn == exu_pkg::FN_SLL) || (cmd.r.fn == exu_pkg::FN_SRL);
    case (cmd.r.fn)
      exu_pkg::FN_ADD: res = a + b;
      exu_pkg::FN_SUB: res = a - b;
      exu_pkg::FN_AND: res = a & b;
      exu_pkg::FN_OR:  res = a | b;
      exu_pkg::FN_XOR: res = a ^ b;
      exu_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      exu_pkg::FN_SLL: res = a << b[`EXU_SHAMT_W-1:0];
      default:         res = a >> b[`EXU_SHAMT_W-1:0];
    endcase
    // x0 keeps its zero
    if (cmd.r.rd != '0) begin
      mirror[cmd.r.rd] = res;
    end
    tbl_cmd.push_back(cmd);
    tbl_exp.push_back(res);
    tbl_lat.push_back(shift ? int'(b[`EXU_SHAMT_W-1:0]) + 2 : 2);
  endfunction

  function automatic void add_r(input exu_pkg::alu_fn_e fn, input int rd, input int rs1,
                                input int rs2);
    exu_pkg::cmd_u cmd;
    cmd            = '0;
    cmd.r.imm_flag = 1'b0;
    cmd.r.fn       = fn;
    cmd.r.rd       = 5'(rd);
    cmd.r.rs1      = 5'(rs1);
    cmd.r.rs2      = 5'(rs2);
    append_entry(cmd);
  endfunction

  function automatic void add_i(input exu_pkg::alu_fn_e fn, input int rd, input int rs1,
                                input int imm);
    exu_pkg::cmd_u cmd;
    cmd            = '0;
    cmd.i.imm_flag = 1'b1;
    cmd.i.fn       = fn;
    cmd.i.rd       = 5'(rd);
    cmd.i.rs1      = 5'(rs1);
    cmd.i.imm      = 18'(imm);
    append_entry(cmd);
  endfunction

  function automatic void build_table();
    foreach (mirror[k]) begin
      mirror[k] = '0;
    end
    // Sampled registers read zero after reset
    add_r(exu_pkg::FN_OR, 1, 1, 0);
    add_r(exu_pkg::FN_OR, 7, 7, 0);
    add_r(exu_pkg::FN_OR, 15, 15, 0);
    add_r(exu_pkg::FN_OR, 31, 31, 0);
    // Known values from immediates, both signs and both range ends
    add_i(exu_pkg::FN_ADD, 1, 0, 1234);
    add_i(exu_pkg::FN_ADD, 2, 0, -5);
    add_i(exu_pkg::FN_ADD, 3, 0, 131071);
    add_i(exu_pkg::FN_ADD, 4, 0, -131072);
    add_i(exu_pkg::FN_AND, 5, 2, 4080);
    add_i(exu_pkg::FN_OR, 6, 1, -256);
    add_i(exu_pkg::FN_XOR, 7, 3, -1);
    add_i(exu_pkg::FN_SUB, 8, 1, 300);
    add_i(exu_pkg::FN_SUB, 9, 2, -10);
    // Register-register ALU ops
    add_r(exu_pkg::FN_ADD, 10, 1, 3);
    add_r(exu_pkg::FN_SUB, 11, 1, 3);
    add_r(exu_pkg::FN_AND, 12, 6, 7);
    add_r(exu_pkg::FN_OR, 13, 2, 4);
    add_r(exu_pkg::FN_XOR, 14, 10, 11);
    add_r(exu_pkg::FN_SLT, 15, 2, 1);
    add_r(exu_pkg::FN_SLT, 16, 1, 2);
    add_r(exu_pkg::FN_SLT, 17, 4, 2);
    add_r(exu_pkg::FN_SLT, 18, 3, 3);
    // Reads of freshly written destinations
    add_r(exu_pkg::FN_ADD, 19, 10, 10);
    add_i(exu_pkg::FN_ADD, 20, 19, 0);
    // Signed compare across the overflow boundary
    add_i(exu_pkg::FN_ADD, 21, 0, 1);
    add_i(exu_pkg::FN_SLL, 22, 21, 31);
    add_i(exu_pkg::FN_XOR, 23, 22, -1);
    add_r(exu_pkg::FN_SLT, 24, 22, 23);
    add_r(exu_pkg::FN_SLT, 25, 23, 22);
    // Shifts by immediate, amounts 0, 1, 17 and 31
    add_i(exu_pkg::FN_ADD, 26, 0, 17);
    add_i(exu_pkg::FN_ADD, 27, 0, 31);
    add_i(exu_pkg::FN_SLL, 28, 1, 0);
    add_i(exu_pkg::FN_SRL, 28, 2, 1);
    add_i(exu_pkg::FN_SLL, 29, 1, 17);
    add_i(exu_pkg::FN_SRL, 29, 2, 31);
    // Amount taken from the low bits of a negative immediate
    add_i(exu_pkg::FN_SRL, 9, 7, -1);
    // Shifts by register
    add_r(exu_pkg::FN_SLL, 30, 2, 0);
    add_r(exu_pkg::FN_SRL, 30, 2, 21);
    add_r(exu_pkg::FN_SLL, 30, 6, 26);
    add_r(exu_pkg::FN_SRL, 31, 22, 27);
    add_r(exu_pkg::FN_SLL, 31, 21, 27);
    // x0 as destination answers with the value but keeps zero
    add_i(exu_pkg::FN_ADD, 0, 1, 5);
    add_r(exu_pkg::FN_ADD, 25, 0, 0);
    add_r(exu_pkg::FN_XOR, 24, 0, 1);
    add_i(exu_pkg::FN_SLL, 0, 1, 4);
    add_r(exu_pkg::FN_OR, 23, 0, 0);
  endfunction

  ////////////////////////////////////////
  // Command driver and response checks
  ////////////////////////////////////////

  // Entered and left one drive delay after a rising edge
  // Outputs are sampled at the falling edge
  task automatic run_entry(input int idx);
    exu_pkg::alu_fn_e       fn;
    string                  kind;
    logic [`EXU_DATA_W-1:0] held;
    int                     lat;
    int                     err_before;
    err_before = err_cnt;
    fn         = tbl_cmd[idx].r.fn;
    kind       = tbl_cmd[idx].r.imm_flag ? "imm" : "reg";
    cmd_i       = tbl_cmd[idx];
    cmd_valid_i = 1'b1;
    @(negedge clk);
    while (!cmd_ready_o) begin
      @(posedge clk);
      #(DRIVE_DLY);
      @(negedge clk);
    end
    // Accept edge
    @(posedge clk);
    #(DRIVE_DLY);
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    // Edges from acceptance to the rise of rsp_valid_o
    lat = 0;
    @(negedge clk);
    while (!rsp_valid_o) begin
      assert (!cmd_ready_o) else begin
        $display("[FAIL] %0t test %0d: cmd_ready_o high while busy", $time, idx);
        err_cnt++;
      end
      @(posedge clk);
      #(DRIVE_DLY);
      lat++;
      @(negedge clk);
    end
    assert (lat == tbl_lat[idx]) else begin
      $display("[FAIL] %0t test %0d: latency %0d, expected %0d", $time, idx, lat, tbl_lat[idx]);
      err_cnt++;
    end
    held = rsp_data_o;
    // Response must hold through back-pressure
    while (!rsp_ready_i) begin
      @(posedge clk);
      #(DRIVE_DLY);
      @(negedge clk);
      assert (rsp_valid_o && !cmd_ready_o && rsp_data_o == held) else begin
        $display("[FAIL] %0t test %0d: response changed under back-pressure, data %h was %h",
                 $time, idx, rsp_data_o, held);
        err_cnt++;
      end
    end
    assert (held == tbl_exp[idx]) else begin
      $display("[FAIL] %0t test %0d: result %h, expected %h", $time, idx, held, tbl_exp[idx]);
      err_cnt++;
    end
    // Handshake edge, then idle with no second response
    @(posedge clk);
    @(negedge clk);
    assert (!rsp_valid_o && cmd_ready_o) else begin
      $display("[FAIL] %0t test %0d: not idle after handshake, rsp_valid_o %b cmd_ready_o %b",
               $time, idx, rsp_valid_o, cmd_ready_o);
      err_cnt++;
    end
    @(posedge clk);
    #(DRIVE_DLY);
    if (err_cnt == err_before) begin
      pass_cnt++;
    end
    $display("test %0d %s %s rd=x%0d result %h expected %h latency %0d %s", idx, fn.name(),
             kind, tbl_cmd[idx].r.rd, held, tbl_exp[idx], lat,
             (err_cnt == err_before) ? "pass" : "fail");
  endtask

  ////////////////////////////////////////
  // Processes
  ////////////////////////////////////////

  // Random response back-pressure
  initial begin : ready_driver
    int rnd;
    seed        = 32'h7457;
    rsp_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      #(DRIVE_DLY);
      rnd         = $random(seed);
      rsp_ready_i = rnd[0];
    end
  end

  // Handshake seen mid-cycle completes on the next edge
  initial begin : rsp_monitor
    rsp_seen = 0;
    forever begin
      @(negedge clk);
      if (rst_n && rsp_valid_o && rsp_ready_i) begin
        rsp_seen++;
      end
    end
  end

  // Budget scales with the table length
  initial begin : watchdog
    wait (num_tests != 0);
    wait (rst_n === 1'b1);
    repeat (num_tests * CYCLES_PER_TEST) @(posedge clk);
    $display("Watchdog timeout: no progress after %0d cycles, the DUT appears hung",
             num_tests * CYCLES_PER_TEST);
    $display("Test FAILED");
    $finish;
  end

  initial begin : main
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    err_cnt     = 0;
    pass_cnt    = 0;
    num_tests   = 0;
    build_table();
    num_tests = tbl_cmd.size();
    wait (rst_n === 1'b1);
    @(negedge clk);
    assert (cmd_ready_o === 1'b1 && rsp_valid_o === 1'b0) else begin
      $display("[FAIL] %0t reset state: cmd_ready_o %b rsp_valid_o %b",
               $time, cmd_ready_o, rsp_valid_o);
      err_cnt++;
    end
    @(posedge clk);
    #(DRIVE_DLY);
    for (int idx = 0; idx < num_tests; idx++) begin
      run_entry(idx);
    end
    // Exactly one response per command
    assert (rsp_seen == num_tests) else begin
      $display("[FAIL] %0t response count %0d, expected %0d", $time, rsp_seen, num_tests);
      err_cnt++;
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d responses, %0d errors",
             num_tests, pass_cnt, num_tests - pass_cnt, rsp_seen, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* exu.f */
+incdir+logic
logic/exu_pkg.sv
logic/regfile_ff.sv
logic/exu_alu.sv
logic/exu_shift_timer.sv
logic/exu_ctrl_fsm.sv
logic/exu_top.sv
test/tb_clkgen.sv
test/tb_exu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the EXU testbench with Verilator

ROOT=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
  --top-module tb_exu -Mdir "$OBJ_DIR" -o sim_exu -f exu.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/sim_exu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if ! grep -q "Test OK" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0
